//--- project.f
+incdir+.
mips_pkg.sv
instr_decode.sv
alu.sv
exec_writeback.sv
mips_exec_unit.sv
tb_mips_exec_unit.sv

//--- Bender.yml
package:
  name: mips_exec_unit

sources:
  - include_dirs:
      - .
    files:
      - mips_pkg.sv
      - instr_decode.sv
      - alu.sv
      - exec_writeback.sv
      - mips_exec_unit.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_mips_exec_unit.sv

//--- tb_mips_exec_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "mips_defs.svh"

module tb_mips_exec_unit import mips_pkg::*; ();

    localparam int K_NONE    = 0;
    localparam int K_RESULT  = 1;
    localparam int K_BRANCH  = 2;
    localparam int K_ILLEGAL = 3;

    logic        clk;
    logic        reset;
    instr_word_u instr;
    logic [31:0] rs_val;
    logic [31:0] rt_val;
    logic        fetch;
    logic        exec1;
    logic        exec2;
    exec_resp_t  resp;
    logic        result_valid;
    logic        branch_valid;
    logic        branch_taken;
    logic        illegal;
    logic [3:0]  pulses;

    // Model state and the prediction for the current instruction.
    logic [31:0] hi_m;
    logic [31:0] lo_m;
    logic [31:0] next_hi;
    logic [31:0] next_lo;
    logic        hilo_write;
    int          exp_kind;
    logic [31:0] exp_res;
    logic [4:0]  exp_dest;
    logic        exp_taken;
    logic [3:0]  exp_pulses;
    logic [31:0] cur_w;
    logic [31:0] cur_a;
    logic [31:0] cur_b;
    int          n;
    int          idle;

    logic [5:0] special_fns [22] = '{
        `FUNCT_SLL, `FUNCT_SRL, `FUNCT_SRA, `FUNCT_SLLV, `FUNCT_SRLV, `FUNCT_SRAV,
        `FUNCT_JR, `FUNCT_MFHI, `FUNCT_MTHI, `FUNCT_MFLO, `FUNCT_MTLO,
        `FUNCT_MULT, `FUNCT_MULTU, `FUNCT_DIV, `FUNCT_DIVU, `FUNCT_ADDU, `FUNCT_SUBU,
        `FUNCT_AND, `FUNCT_OR, `FUNCT_XOR, `FUNCT_SLT, `FUNCT_SLTU
    };
    logic [5:0] itype_opcodes [19] = '{
        `OPC_BEQ, `OPC_BNE, `OPC_BLEZ, `OPC_BGTZ, `OPC_ADDIU, `OPC_SLTI, `OPC_SLTIU,
        `OPC_ANDI, `OPC_ORI, `OPC_XORI, `OPC_LUI, `OPC_LB, `OPC_LH, `OPC_LW,
        `OPC_LBU, `OPC_LHU, `OPC_SB, `OPC_SH, `OPC_SW
    };

    assign pulses = {result_valid, branch_valid, branch_taken, illegal};

    mips_exec_unit dut_i (
        .clk          (clk),
        .reset        (reset),
        .instr        (instr),
        .rs_val       (rs_val),
        .rt_val       (rt_val),
        .fetch        (fetch),
        .exec1        (exec1),
        .exec2        (exec2),
        .resp         (resp),
        .result_valid (result_valid),
        .branch_valid (branch_valid),
        .branch_taken (branch_taken),
        .illegal      (illegal)
    );

    always #5 clk = ~clk;

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("FAIL at %0t: %s for instr %h: got %h, expected %h",
                     $time, what, cur_w, got, exp);
            $display("TB FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // Zero, minus one and the most negative value come up often.
    function automatic logic [31:0] pick_operand();
        case ($urandom % 8)
            0: return 32'h0000_0000;
            1: return 32'hffff_ffff;
            2: return 32'h8000_0000;
            3: return $urandom % 16;
            default: return $urandom;
        endcase
    endfunction

    function automatic logic [31:0] illegal_word(input logic [31:0] base);
        logic [31:0] iw;
        iw = base;
        case ($urandom % 6)
            0: iw[31:26] = 6'h02; // J
            1: iw[31:26] = 6'h03; // JAL
            2: iw[31:26] = 6'h08; // ADDI
            3: iw[31:26] = 6'h22; // LWL
            4: begin
                iw[31:26] = `OPC_SPECIAL;
                iw[5:0]   = 6'h20; // ADD
            end
            default: begin
                iw[31:26] = `OPC_REGIMM;
                iw[20:16] = 5'h10; // BLTZAL
            end
        endcase
        return iw;
    endfunction

    task automatic gen_instr(input bit first);
        int r;
        r     = $urandom % 16;
        cur_w = $urandom;
        cur_a = pick_operand();
        cur_b = pick_operand();
        if (first || hilo_write) begin
            // Read back HI or LO right after they may have changed.
            cur_w[31:26] = `OPC_SPECIAL;
            cur_w[5:0]   = (first || ($urandom % 2 == 0)) ? `FUNCT_MFHI : `FUNCT_MFLO;
        end else if (r < 6) begin
            cur_w[31:26] = `OPC_SPECIAL;
            cur_w[5:0]   = special_fns[$urandom % 22];
        end else if (r == 6) begin
            cur_w[31:26] = `OPC_REGIMM;
            cur_w[20:16] = {4'h0, cur_w[16]};
        end else if (r < 15) begin
            cur_w[31:26] = itype_opcodes[$urandom % 19];
        end else begin
            cur_w = illegal_word(cur_w);
        end
        if (cur_w[31:26] == `OPC_SPECIAL &&
            (cur_w[5:0] == `FUNCT_DIV || cur_w[5:0] == `FUNCT_DIVU)) begin
            case ($urandom % 4)
                0: cur_b = 32'h0;
                1: begin
                    cur_a = 32'h8000_0000;
                    cur_b = 32'hffff_ffff;
                end
                default: ;
            endcase
        end
    endtask

    task automatic predict(input logic [31:0] iw, input logic [31:0] a, input logic [31:0] b);
        logic [31:0] sx;
        logic [31:0] zx;
        logic [31:0] ma;
        logic [31:0] mb;
        sx         = {{16{iw[15]}}, iw[15:0]};
        zx         = {16'h0000, iw[15:0]};
        exp_kind   = K_RESULT;
        exp_res    = '0;
        exp_dest   = iw[20:16];
        exp_taken  = 1'b0;
        hilo_write = 1'b0;
        next_hi    = hi_m;
        next_lo    = lo_m;
        case (iw[31:26])
            `OPC_SPECIAL: begin
                exp_dest = iw[15:11];
                case (iw[5:0])
                    `FUNCT_ADDU: exp_res = a + b;
                    `FUNCT_SUBU: exp_res = a - b;
                    `FUNCT_AND:  exp_res = a & b;
                    `FUNCT_OR:   exp_res = a | b;
                    `FUNCT_XOR:  exp_res = a ^ b;
                    `FUNCT_SLT:  exp_res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    `FUNCT_SLTU: exp_res = (a < b) ? 32'd1 : 32'd0;
                    `FUNCT_SLL:  exp_res = b << iw[10:6];
                    `FUNCT_SRL:  exp_res = b >> iw[10:6];
                    `FUNCT_SRA:  exp_res = $signed(b) >>> iw[10:6];
                    `FUNCT_SLLV: exp_res = b << a[4:0];
                    `FUNCT_SRLV: exp_res = b >> a[4:0];
                    `FUNCT_SRAV: exp_res = $signed(b) >>> a[4:0];
                    `FUNCT_MFHI: exp_res = hi_m;
                    `FUNCT_MFLO: exp_res = lo_m;
                    `FUNCT_JR:   exp_kind = K_NONE;
                    `FUNCT_MTHI: next_hi = a;
                    `FUNCT_MTLO: next_lo = a;
                    `FUNCT_MULT: {next_hi, next_lo} = {{32{a[31]}}, a} * {{32{b[31]}}, b};
                    `FUNCT_MULTU: {next_hi, next_lo} = {32'h0, a} * {32'h0, b};
                    `FUNCT_DIV: begin
                        // Divide magnitudes, then apply the signs.
                        if (b != 0) begin
                            ma      = a[31] ? -a : a;
                            mb      = b[31] ? -b : b;
                            next_lo = (a[31] ^ b[31]) ? -(ma / mb) : ma / mb;
                            next_hi = a[31] ? -(ma % mb) : ma % mb;
                        end
                    end
                    `FUNCT_DIVU: begin
                        if (b != 0) begin
                            next_lo = a / b;
                            next_hi = a % b;
                        end
                    end
                    default: exp_kind = K_ILLEGAL;
                endcase
                case (iw[5:0])
                    `FUNCT_MTHI, `FUNCT_MTLO, `FUNCT_MULT, `FUNCT_MULTU,
                    `FUNCT_DIV, `FUNCT_DIVU: begin
                        exp_kind   = K_NONE;
                        hilo_write = 1'b1;
                    end
                    default: ;
                endcase
            end
            `OPC_REGIMM: begin
                exp_kind = K_BRANCH;
                case (iw[20:16])
                    `RT_BLTZ: exp_taken = a[31];
                    `RT_BGEZ: exp_taken = !a[31];
                    default:  exp_kind = K_ILLEGAL;
                endcase
            end
            `OPC_BEQ, `OPC_BNE, `OPC_BLEZ, `OPC_BGTZ: begin
                exp_kind = K_BRANCH;
                case (iw[31:26])
                    `OPC_BEQ:  exp_taken = (a == b);
                    `OPC_BNE:  exp_taken = (a != b);
                    `OPC_BLEZ: exp_taken = a[31] || (a == 0);
                    default:   exp_taken = !a[31] && (a != 0);
                endcase
            end
            `OPC_ADDIU, `OPC_LB, `OPC_LH, `OPC_LW, `OPC_LBU, `OPC_LHU: exp_res = a + sx;
            `OPC_SLTI:  exp_res = ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0;
            `OPC_SLTIU: exp_res = (a < sx) ? 32'd1 : 32'd0;
            `OPC_ANDI:  exp_res = a & zx;
            `OPC_ORI:   exp_res = a | zx;
            `OPC_XORI:  exp_res = a ^ zx;
            `OPC_LUI:   exp_res = {iw[15:0], 16'h0000};
            `OPC_SB, `OPC_SH, `OPC_SW: exp_kind = K_NONE;
            default:    exp_kind = K_ILLEGAL;
        endcase
        case (exp_kind)
            K_RESULT:  exp_pulses = 4'b1000;
            K_BRANCH:  exp_pulses = {2'b01, exp_taken, 1'b0};
            K_ILLEGAL: exp_pulses = 4'b0001;
            default:   exp_pulses = 4'b0000;
        endcase
    endtask

    task automatic wait_pulse(input string name);
        int cycles;
        cycles = 0;
        while (!(result_valid || branch_valid || illegal)) begin
            if (cycles == 8) begin
                $display("Timeout: %s never came after exec1 at %0t", name, $time);
                $display("TB FAILED");
                $fatal(1, "no pulse");
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
        check(cycles, 0, "pulse delay after exec1");
    endtask

    initial begin
        void'($urandom(32'h233a0d01));
        clk        = 1'b0;
        reset      = 1'b1;
        instr      = '0;
        rs_val     = '0;
        rt_val     = '0;
        fetch      = 1'b0;
        exec1      = 1'b0;
        exec2      = 1'b0;
        hi_m       = '0;
        lo_m       = '0;
        hilo_write = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (n = 0; n < 2000; n++) begin
            gen_instr(n == 0);
            predict(cur_w, cur_a, cur_b);
            instr  = cur_w;
            rs_val = cur_a;
            rt_val = cur_b;
            fetch  = 1'b1;
            @(negedge clk);
            fetch  = 1'b0;
            // Decode must hold the request, so change the inputs.
            instr  = $urandom;
            rs_val = $urandom;
            rt_val = $urandom;
            check(pulses, 4'b0000, "pulse before exec1");
            idle = $urandom % 4;
            repeat (idle) begin
                @(negedge clk);
                check(pulses, 4'b0000, "pulse before exec1");
            end
            exec1 = 1'b1;
            @(negedge clk);
            exec1 = 1'b0;
            case (exp_kind)
                K_RESULT:  wait_pulse("result_valid");
                K_BRANCH:  wait_pulse("branch_valid");
                K_ILLEGAL: wait_pulse("illegal");
                default: ;
            endcase
            check(pulses, exp_pulses, "pulses after exec1");
            if (exp_kind == K_RESULT) begin
                check(resp.result, exp_res, "result");
                check(resp.dest, exp_dest, "dest");
                check(resp.writes_reg, 1'b1, "writes_reg");
            end else begin
                // Non-writers carry no destination.
                check(resp.writes_reg, 1'b0, "writes_reg");
                if (exp_kind != K_ILLEGAL) begin
                    check(resp.dest, 5'd0, "dest");
                end
            end
            @(negedge clk);
            check(pulses, 4'b0000, "pulse longer than one cycle");
            repeat ($urandom % 3) @(negedge clk);
            exec2 = 1'b1;
            @(negedge clk);
            exec2 = 1'b0;
            hi_m  = next_hi;
            lo_m  = next_lo;
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- mips_exec_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "mips_defs.svh"

module mips_exec_unit import mips_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  instr_word_u            instr,
    input  logic [`DATA_WIDTH-1:0] rs_val,
    input  logic [`DATA_WIDTH-1:0] rt_val,
    input  logic                   fetch,
    input  logic                   exec1,
    input  logic                   exec2,
    output exec_resp_t             resp,
    output logic                   result_valid,
    output logic                   branch_valid,
    output logic                   branch_taken,
    output logic                   illegal
);

    exec_req_t              req;
    logic [`DATA_WIDTH-1:0] result;
    alu_flags_t             flags;

    instr_decode decode_i (
        .clk    (clk),
        .reset  (reset),
        .instr  (instr),
        .rs_val (rs_val),
        .rt_val (rt_val),
        .fetch  (fetch),
        .req    (req)
    );

    alu alu_i (
        .clk    (clk),
        .reset  (reset),
        .req    (req),
        .exec2  (exec2),
        .result (result),
        .flags  (flags)
    );

    exec_writeback writeback_i (
        .clk          (clk),
        .reset        (reset),
        .req          (req),
        .result       (result),
        .flags        (flags),
        .exec1        (exec1),
        .resp         (resp),
        .result_valid (result_valid),
        .branch_valid (branch_valid),
        .branch_taken (branch_taken),
        .illegal      (illegal)
    );

endmodule

`default_nettype wire

//--- exec_writeback.sv
`timescale 1ns/100ps
`default_nettype none

`include "mips_defs.svh"

module exec_writeback import mips_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  exec_req_t              req,
    input  logic [`DATA_WIDTH-1:0] result,
    input  alu_flags_t             flags,
    input  logic                   exec1,
    output exec_resp_t             resp,
    output logic                   result_valid,
    output logic                   branch_valid,
    output logic                   branch_taken,
    output logic                   illegal
);

    logic taken;

    always_comb begin
        case (req.op)
            OP_BEQ:  taken = flags.zero;
            OP_BNE:  taken = !flags.zero;
            OP_BGTZ: taken = flags.positive;
            OP_BLEZ: taken = !flags.positive;
            OP_BLTZ: taken = flags.negative;
            OP_BGEZ: taken = !flags.negative;
            default: taken = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            resp         <= '0;
            result_valid <= 1'b0;
            branch_valid <= 1'b0;
            branch_taken <= 1'b0;
            illegal      <= 1'b0;
        end else begin
            if (exec1) begin
                resp.result     <= result;
                resp.dest       <= req.dest;
                resp.writes_reg <= req.writes_reg;
            end
            // Pulses last one cycle.
            result_valid <= exec1 && req.writes_reg;
            branch_valid <= exec1 && req.is_branch;
            branch_taken <= exec1 && req.is_branch && taken;
            illegal      <= exec1 && (req.op == OP_ILLEGAL);
        end
    end

endmodule

`default_nettype wire

//--- alu.sv
`timescale 1ns/100ps
`default_nettype none

`include "mips_defs.svh"

module alu import mips_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  exec_req_t              req,
    input  logic                   exec2,
    output logic [`DATA_WIDTH-1:0] result,
    output alu_flags_t             flags
);

    logic signed [`DATA_WIDTH-1:0]   a_s;
    logic signed [`DATA_WIDTH-1:0]   b_s;
    logic signed [`DATA_WIDTH-1:0]   cmp_b;
    logic [`SHAMT_WIDTH-1:0]         var_sa;
    logic [2*`DATA_WIDTH-1:0]        prod_u;
    logic signed [2*`DATA_WIDTH-1:0] prod_s;
    logic [`DATA_WIDTH-1:0]          most_neg;
    logic                            div_by_zero;
    logic                            div_ovf;
    logic [`DATA_WIDTH-1:0]          quot_u;
    logic [`DATA_WIDTH-1:0]          rem_u;
    logic signed [`DATA_WIDTH-1:0]   quot_s;
    logic signed [`DATA_WIDTH-1:0]   rem_s;
    logic [`DATA_WIDTH-1:0]          hi;
    logic [`DATA_WIDTH-1:0]          lo;

    assign a_s    = req.a;
    assign b_s    = req.b;
    assign var_sa = req.a[`SHAMT_WIDTH-1:0];

    assign most_neg    = {1'b1, {(`DATA_WIDTH-1){1'b0}}};
    assign div_by_zero = (req.b == '0);
    assign div_ovf     = (req.a == most_neg) && (req.b == '1);

    assign prod_u = {{`DATA_WIDTH{1'b0}}, req.a} * {{`DATA_WIDTH{1'b0}}, req.b};
    assign prod_s = a_s * b_s;

    // Quotient truncates toward zero, remainder follows the dividend.
    always_comb begin
        quot_u = '0;
        rem_u  = '0;
        quot_s = '0;
        rem_s  = '0;
        if (!div_by_zero) begin
            quot_u = req.a / req.b;
            rem_u  = req.a % req.b;
            if (div_ovf) begin
                quot_s = most_neg;
                rem_s  = '0;
            end else begin
                quot_s = a_s / b_s;
                rem_s  = a_s % b_s;
            end
        end
    end

    always_comb begin
        result = '0;
        case (req.op)
            OP_ADDU, OP_ADDIU,
            OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW,
            OP_SB, OP_SH, OP_SW:   result = req.a + req.b;
            OP_SUBU:               result = req.a - req.b;
            OP_AND, OP_ANDI:       result = req.a & req.b;
            OP_OR, OP_ORI:         result = req.a | req.b;
            OP_XOR, OP_XORI:       result = req.a ^ req.b;
            OP_LUI:                result = req.b; // Immediate already shifted.
            OP_SLT, OP_SLTI:       result = {{(`DATA_WIDTH-1){1'b0}}, a_s < b_s};
            OP_SLTU, OP_SLTIU:     result = {{(`DATA_WIDTH-1){1'b0}}, req.a < req.b};
            OP_SLL:                result = req.b << req.sa;
            OP_SRL:                result = req.b >> req.sa;
            OP_SRA:                result = b_s >>> req.sa;
            OP_SLLV:               result = req.b << var_sa;
            OP_SRLV:               result = req.b >> var_sa;
            OP_SRAV:               result = b_s >>> var_sa;
            OP_MFHI:               result = hi;
            OP_MFLO:               result = lo;
            default:               result = '0;
        endcase
    end

    // Two-operand branches compare against rt, the rest against zero.
    assign cmp_b = (req.op == OP_BEQ || req.op == OP_BNE) ? b_s : '0;

    always_comb begin
        flags.zero     = (a_s == cmp_b);
        flags.positive = (a_s > cmp_b);
        flags.negative = (a_s < cmp_b);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (exec2) begin
            case (req.op)
                OP_MULT:  {hi, lo} <= prod_s;
                OP_MULTU: {hi, lo} <= prod_u;
                OP_DIV: begin
                    if (!div_by_zero) begin
                        hi <= rem_s;
                        lo <= quot_s;
                    end
                end
                OP_DIVU: begin
                    if (!div_by_zero) begin
                        hi <= rem_u;
                        lo <= quot_u;
                    end
                end
                OP_MTHI:  hi <= req.a;
                OP_MTLO:  lo <= req.a;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- instr_decode.sv
`timescale 1ns/100ps
`default_nettype none

`include "mips_defs.svh"

module instr_decode import mips_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  instr_word_u            instr,
    input  logic [`DATA_WIDTH-1:0] rs_val,
    input  logic [`DATA_WIDTH-1:0] rt_val,
    input  logic                   fetch,
    output exec_req_t              req
);

    alu_op_e                op;
    exec_req_t              next_req;
    logic [`DATA_WIDTH-1:0] imm_sext;
    logic [`DATA_WIDTH-1:0] imm_zext;

    assign imm_sext = {{(`DATA_WIDTH-16){instr.i.imm[15]}}, instr.i.imm};
    assign imm_zext = {{(`DATA_WIDTH-16){1'b0}}, instr.i.imm};

    // Opcode first, then funct or the REGIMM rt field.
    always_comb begin
        op = OP_ILLEGAL;
        case (instr.r.opcode)
            `OPC_SPECIAL: begin
                case (instr.r.funct)
                    `FUNCT_SLL:   op = OP_SLL;
                    `FUNCT_SRL:   op = OP_SRL;
                    `FUNCT_SRA:   op = OP_SRA;
                    `FUNCT_SLLV:  op = OP_SLLV;
                    `FUNCT_SRLV:  op = OP_SRLV;
                    `FUNCT_SRAV:  op = OP_SRAV;
                    `FUNCT_JR:    op = OP_JR;
                    `FUNCT_MFHI:  op = OP_MFHI;
                    `FUNCT_MTHI:  op = OP_MTHI;
                    `FUNCT_MFLO:  op = OP_MFLO;
                    `FUNCT_MTLO:  op = OP_MTLO;
                    `FUNCT_MULT:  op = OP_MULT;
                    `FUNCT_MULTU: op = OP_MULTU;
                    `FUNCT_DIV:   op = OP_DIV;
                    `FUNCT_DIVU:  op = OP_DIVU;
                    `FUNCT_ADDU:  op = OP_ADDU;
                    `FUNCT_SUBU:  op = OP_SUBU;
                    `FUNCT_AND:   op = OP_AND;
                    `FUNCT_OR:    op = OP_OR;
                    `FUNCT_XOR:   op = OP_XOR;
                    `FUNCT_SLT:   op = OP_SLT;
                    `FUNCT_SLTU:  op = OP_SLTU;
                    default:      op = OP_ILLEGAL;
                endcase
            end
            `OPC_REGIMM: begin
                case (instr.i.rt)
                    `RT_BLTZ: op = OP_BLTZ;
                    `RT_BGEZ: op = OP_BGEZ;
                    default:  op = OP_ILLEGAL; // Linking forms not supported.
                endcase
            end
            `OPC_BEQ:   op = OP_BEQ;
            `OPC_BNE:   op = OP_BNE;
            `OPC_BLEZ:  op = OP_BLEZ;
            `OPC_BGTZ:  op = OP_BGTZ;
            `OPC_ADDIU: op = OP_ADDIU;
            `OPC_SLTI:  op = OP_SLTI;
            `OPC_SLTIU: op = OP_SLTIU;
            `OPC_ANDI:  op = OP_ANDI;
            `OPC_ORI:   op = OP_ORI;
            `OPC_XORI:  op = OP_XORI;
            `OPC_LUI:   op = OP_LUI;
            `OPC_LB:    op = OP_LB;
            `OPC_LH:    op = OP_LH;
            `OPC_LW:    op = OP_LW;
            `OPC_LBU:   op = OP_LBU;
            `OPC_LHU:   op = OP_LHU;
            `OPC_SB:    op = OP_SB;
            `OPC_SH:    op = OP_SH;
            `OPC_SW:    op = OP_SW;
            default:    op = OP_ILLEGAL;
        endcase
    end

    // Operands and destination.
    always_comb begin
        next_req.op         = op;
        next_req.a          = rs_val;
        next_req.b          = rt_val;
        next_req.sa         = instr.r.shamt;
        next_req.dest       = '0;
        next_req.writes_reg = 1'b0;
        next_req.is_branch  = 1'b0;
        case (op)
            OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_SLTU,
            OP_SLL, OP_SRL, OP_SRA, OP_SLLV, OP_SRLV, OP_SRAV,
            OP_MFHI, OP_MFLO: begin
                next_req.dest       = instr.r.rd;
                next_req.writes_reg = 1'b1;
            end
            OP_ADDIU, OP_SLTI, OP_SLTIU,
            OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW: begin
                next_req.b          = imm_sext;
                next_req.dest       = instr.i.rt;
                next_req.writes_reg = 1'b1;
            end
            OP_SB, OP_SH, OP_SW: next_req.b = imm_sext; // Address only.
            OP_ANDI, OP_ORI, OP_XORI: begin
                next_req.b          = imm_zext;
                next_req.dest       = instr.i.rt;
                next_req.writes_reg = 1'b1;
            end
            OP_LUI: begin
                next_req.a          = '0;
                next_req.b          = {instr.i.imm, 16'h0000};
                next_req.dest       = instr.i.rt;
                next_req.writes_reg = 1'b1;
            end
            OP_BEQ, OP_BNE, OP_BGTZ, OP_BLEZ, OP_BLTZ, OP_BGEZ: begin
                next_req.is_branch  = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            req    <= '0;
            req.op <= OP_NOP;
        end else if (fetch) begin
            req <= next_req;
        end
    end

endmodule

`default_nettype wire

//--- mips_pkg.sv
`default_nettype none

`include "mips_defs.svh"

package mips_pkg;

    typedef enum logic [6:0] {
        OP_NOP,
        OP_ILLEGAL,
        // Register ALU ops.
        OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_SLTU,
        OP_SLL, OP_SRL, OP_SRA, OP_SLLV, OP_SRLV, OP_SRAV,
        // HI/LO group.
        OP_MULT, OP_MULTU, OP_DIV, OP_DIVU,
        OP_MFHI, OP_MFLO, OP_MTHI, OP_MTLO,
        OP_JR,
        // Immediate forms.
        OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI, OP_SLTIU, OP_LUI,
        // Address only.
        OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW,
        OP_SB, OP_SH, OP_SW,
        OP_BEQ, OP_BNE, OP_BGTZ, OP_BLEZ, OP_BLTZ, OP_BGEZ
    } alu_op_e;

    typedef struct packed {
        logic [5:0]                   opcode;
        logic [`REG_IDX_WIDTH-1:0]    rs;
        logic [`REG_IDX_WIDTH-1:0]    rt;
        logic [`REG_IDX_WIDTH-1:0]    rd;
        logic [`SHAMT_WIDTH-1:0]      shamt;
        logic [5:0]                   funct;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]                   opcode;
        logic [`REG_IDX_WIDTH-1:0]    rs;
        logic [`REG_IDX_WIDTH-1:0]    rt;
        logic [15:0]                  imm;
    } i_fields_t;

    // Same 32 bits, two field layouts.
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_word_u;

    typedef struct packed {
        alu_op_e                      op;
        logic [`DATA_WIDTH-1:0]       a;
        logic [`DATA_WIDTH-1:0]       b;
        logic [`SHAMT_WIDTH-1:0]      sa;
        logic [`REG_IDX_WIDTH-1:0]    dest;
        logic                         writes_reg;
        logic                         is_branch;
    } exec_req_t;

    // Signed compare of a against b, or of a against zero.
    typedef struct packed {
        logic zero;
        logic positive;
        logic negative;
    } alu_flags_t;

    typedef struct packed {
        logic [`DATA_WIDTH-1:0]       result;
        logic [`REG_IDX_WIDTH-1:0]    dest;
        logic                         writes_reg;
    } exec_resp_t;

endpackage

`default_nettype wire

//--- mips_defs.svh
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

`define DATA_WIDTH    32
`define SHAMT_WIDTH   5
`define REG_IDX_WIDTH 5

// Primary opcodes.
`define OPC_SPECIAL 6'h00
`define OPC_REGIMM  6'h01
`define OPC_BEQ     6'h04
`define OPC_BNE     6'h05
`define OPC_BLEZ    6'h06
`define OPC_BGTZ    6'h07
`define OPC_ADDIU   6'h09
`define OPC_SLTI    6'h0a
`define OPC_SLTIU   6'h0b
`define OPC_ANDI    6'h0c
`define OPC_ORI     6'h0d
`define OPC_XORI    6'h0e
`define OPC_LUI     6'h0f
`define OPC_LB      6'h20
`define OPC_LH      6'h21
`define OPC_LW      6'h23
`define OPC_LBU     6'h24
`define OPC_LHU     6'h25
`define OPC_SB      6'h28
`define OPC_SH      6'h29
`define OPC_SW      6'h2b

// REGIMM branches, selected by the rt field.
`define RT_BLTZ 5'h00
`define RT_BGEZ 5'h01

// SPECIAL funct codes.
`define FUNCT_SLL   6'h00
`define FUNCT_SRL   6'h02
`define FUNCT_SRA   6'h03
`define FUNCT_SLLV  6'h04
`define FUNCT_SRLV  6'h06
`define FUNCT_SRAV  6'h07
`define FUNCT_JR    6'h08
`define FUNCT_MFHI  6'h10
`define FUNCT_MTHI  6'h11
`define FUNCT_MFLO  6'h12
`define FUNCT_MTLO  6'h13
`define FUNCT_MULT  6'h18
`define FUNCT_MULTU 6'h19
`define FUNCT_DIV   6'h1a
`define FUNCT_DIVU  6'h1b
`define FUNCT_ADDU  6'h21
`define FUNCT_SUBU  6'h23
`define FUNCT_AND   6'h24
`define FUNCT_OR    6'h25
`define FUNCT_XOR   6'h26
`define FUNCT_SLT   6'h2a
`define FUNCT_SLTU  6'h2b

`endif
